/* hw/rv_decode_pkg.sv */
////////////////////
// Shared widths, opcodes and micro-op codes for the RV32I decode stage
// Import inside module bodies, or use scoped names in port lists
////////////////////
package rv_decode_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ALU_SEL_W  = 4;
  localparam int LSU_CTRL_W = 4;  // {store, funct3}
  localparam int KIND_W     = 3;

  ////////////////////
  // Micro-op kinds
  ////////////////////
  localparam logic [KIND_W-1:0] KIND_ALU     = 3'd1;  // OP, OP-IMM, LUI, AUIPC
  localparam logic [KIND_W-1:0] KIND_LOAD    = 3'd2;
  localparam logic [KIND_W-1:0] KIND_STORE   = 3'd3;
  localparam logic [KIND_W-1:0] KIND_BUBBLE  = 3'd4;  // RAW stall slot
  localparam logic [KIND_W-1:0] KIND_NOP     = 3'd5;  // MISC-MEM, SYSTEM
  localparam logic [KIND_W-1:0] KIND_ILLEGAL = 3'd6;

  // Major opcodes
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_MISCMEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

  localparam logic [ALU_SEL_W-1:0] ALU_ADD = 4'b0000;

  localparam logic [2:0] FUNCT3_SLL = 3'b001;
  localparam logic [2:0] FUNCT3_SRL = 3'b101;  // SRL and SRA, split by bit 30

  ////////////////////
  // Instruction word seen through each format
  ////////////////////
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm;  // Shamt sits in imm[4:0]
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i;
    struct packed {
      logic [6:0]            imm_hi;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;
      logic [6:0]            opcode;
    } s;
    struct packed {
      logic [19:0]           imm;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } u;
  } rv_instr_u;

endpackage

/* hw/uop_if.sv */
////////////////////
// One micro-op with valid/ready, from the decoder to the issue register
////////////////////
`timescale 1ns/1ps

interface uop_if;
  import rv_decode_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [KIND_W-1:0]     kind;
  logic [ALU_SEL_W-1:0]  alu_sel;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  logic                  use_pc;   // Operand A is the PC
  logic                  use_imm;  // Operand B is the immediate
  logic                  wb;       // Result goes to rd
  logic [LSU_CTRL_W-1:0] lsu_ctrl;

  modport source (
    output valid, kind, alu_sel, rs1, rs2, rd, imm, use_pc, use_imm, wb, lsu_ctrl,
    input  ready
  );

  modport sink (
    input  valid, kind, alu_sel, rs1, rs2, rd, imm, use_pc, use_imm, wb, lsu_ctrl,
    output ready
  );

endinterface

/* hw/imm_gen.sv */
////////////////////
// Immediate extraction for the I, shift, S and U formats
////////////////////
`timescale 1ns/1ps

module imm_gen (
  input  rv_decode_pkg::rv_instr_u      instr_i,
  output logic [rv_decode_pkg::XLEN-1:0] imm_o
);
  import rv_decode_pkg::*;

  logic [XLEN-1:0] imm_i_ext;
  logic [XLEN-1:0] imm_sh_ext;
  logic [XLEN-1:0] imm_s_ext;
  logic [XLEN-1:0] imm_u_ext;
  logic            is_shift;

  // Sign extension from bit 31 for I and S
  assign imm_i_ext  = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_s_ext  = {{(XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  assign imm_sh_ext = {{(XLEN-5){1'b0}}, instr_i.i.imm[4:0]};  // Shamt, zero extended
  assign imm_u_ext  = {instr_i.u.imm, 12'b0};

  assign is_shift = (instr_i.i.funct3 == FUNCT3_SLL) || (instr_i.i.funct3 == FUNCT3_SRL);

  always_comb begin
    case (instr_i.i.opcode)
      OPC_OPIMM: begin
        if (is_shift) begin
          imm_o = imm_sh_ext;
        end else begin
          imm_o = imm_i_ext;
        end
      end
      OPC_LOAD:  imm_o = imm_i_ext;
      OPC_STORE: imm_o = imm_s_ext;
      OPC_LUI,
      OPC_AUIPC: imm_o = imm_u_ext;
      default:   imm_o = '0;  // OP and everything without an immediate
    endcase
  end

endmodule

/* hw/hazard_tracker.sv */
////////////////////
// RAW check against the last destination; asks for one bubble per hazard
////////////////////
`timescale 1ns/1ps

module hazard_tracker (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  rv_decode_pkg::rv_instr_u  instr_i,
  input  logic                      accept_i,  // Real instruction taken from fetch
  input  logic                      offer_i,   // Bubble handed to issue
  output logic                      bubble_o
);
  import rv_decode_pkg::*;

  logic [REG_ADDR_W-1:0] prev_rd_q;
  logic                  stalled_q;  // Current instruction already got its bubble
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  writes_rd;
  logic                  hit_rs1;
  logic                  hit_rs2;

  always_comb begin
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    writes_rd = 1'b0;
    case (instr_i.r.opcode)
      OPC_OP:    begin uses_rs1 = 1'b1; uses_rs2 = 1'b1; writes_rd = 1'b1; end
      OPC_OPIMM: begin uses_rs1 = 1'b1; writes_rd = 1'b1; end
      OPC_LOAD:  begin uses_rs1 = 1'b1; writes_rd = 1'b1; end
      OPC_STORE: begin uses_rs1 = 1'b1; uses_rs2 = 1'b1; end
      OPC_LUI,
      OPC_AUIPC: writes_rd = 1'b1;
      default:   ;
    endcase
  end

  // x0 never carries a dependency
  assign hit_rs1  = uses_rs1 && (instr_i.r.rs1 != '0) && (instr_i.r.rs1 == prev_rd_q);
  assign hit_rs2  = uses_rs2 && (instr_i.r.rs2 != '0) && (instr_i.r.rs2 == prev_rd_q);
  assign bubble_o = (hit_rs1 || hit_rs2) && !stalled_q;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_rd_q <= '0;
      stalled_q <= 1'b0;
    end else begin
      if (accept_i) begin
        prev_rd_q <= writes_rd ? instr_i.r.rd : '0;
        stalled_q <= 1'b0;
      end else if (offer_i) begin
        stalled_q <= 1'b1;
      end
    end
  end

endmodule

/* hw/decode_ctrl.sv */
////////////////////
// Opcode decode into micro-op fields, with bubble insertion on RAW hazards
// Drives the fetch-side ready and the source side of uop_if
////////////////////
`timescale 1ns/1ps

module decode_ctrl (
  input  logic                     clk_i,
  input  logic                     rstn_i,
  input  rv_decode_pkg::rv_instr_u instr_i,
  input  logic                     instr_valid_i,
  output logic                     instr_ready_o,
  uop_if.source                    uop_o
);
  import rv_decode_pkg::*;

  logic [XLEN-1:0]       imm;
  logic                  bubble;
  logic                  need_bubble;
  logic                  accept;
  logic                  offer;

  logic [KIND_W-1:0]     dec_kind;
  logic [ALU_SEL_W-1:0]  dec_alu_sel;
  logic [REG_ADDR_W-1:0] dec_rs1;
  logic [REG_ADDR_W-1:0] dec_rs2;
  logic [REG_ADDR_W-1:0] dec_rd;
  logic                  dec_use_pc;
  logic                  dec_use_imm;
  logic                  dec_wb;
  logic [LSU_CTRL_W-1:0] dec_lsu_ctrl;
  logic                  is_shift;

  imm_gen imm_gen_i (
    .instr_i (instr_i),
    .imm_o   (imm)
  );

  hazard_tracker hazard_tracker_i (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .instr_i  (instr_i),
    .accept_i (accept),
    .offer_i  (offer),
    .bubble_o (bubble)
  );

  assign is_shift = (instr_i.i.funct3 == FUNCT3_SLL) || (instr_i.i.funct3 == FUNCT3_SRL);

  ////////////////////
  // Field decode
  ////////////////////
  always_comb begin
    dec_kind     = KIND_ILLEGAL;
    dec_alu_sel  = '0;
    dec_rs1      = '0;
    dec_rs2      = '0;
    dec_rd       = '0;
    dec_use_pc   = 1'b0;
    dec_use_imm  = 1'b0;
    dec_wb       = 1'b0;
    dec_lsu_ctrl = '0;
    case (instr_i.r.opcode)
      OPC_OP: begin
        dec_kind    = KIND_ALU;
        dec_alu_sel = {instr_i.r.funct7[5], instr_i.r.funct3};
        dec_rs1     = instr_i.r.rs1;
        dec_rs2     = instr_i.r.rs2;
        dec_rd      = instr_i.r.rd;
        dec_wb      = 1'b1;
      end
      OPC_OPIMM: begin
        dec_kind    = KIND_ALU;
        // Bit 30 only tells SRAI from SRLI; elsewhere it is immediate data
        dec_alu_sel = is_shift ? {instr_i.r.funct7[5], instr_i.i.funct3}
                               : {1'b0, instr_i.i.funct3};
        dec_rs1     = instr_i.i.rs1;
        dec_rd      = instr_i.i.rd;
        dec_use_imm = 1'b1;
        dec_wb      = 1'b1;
      end
      OPC_LUI,
      OPC_AUIPC: begin
        dec_kind    = KIND_ALU;
        dec_alu_sel = ALU_ADD;
        dec_rd      = instr_i.u.rd;
        dec_use_pc  = (instr_i.u.opcode == OPC_AUIPC);
        dec_use_imm = 1'b1;
        dec_wb      = 1'b1;
      end
      OPC_LOAD: begin
        dec_kind     = KIND_LOAD;
        dec_alu_sel  = ALU_ADD;  // Address = rs1 + imm
        dec_rs1      = instr_i.i.rs1;
        dec_rd       = instr_i.i.rd;
        dec_use_imm  = 1'b1;
        dec_wb       = 1'b1;
        dec_lsu_ctrl = {1'b0, instr_i.i.funct3};
      end
      OPC_STORE: begin
        dec_kind     = KIND_STORE;
        dec_alu_sel  = ALU_ADD;
        dec_rs1      = instr_i.s.rs1;
        dec_rs2      = instr_i.s.rs2;  // Store data
        dec_use_imm  = 1'b1;
        dec_lsu_ctrl = {1'b1, instr_i.s.funct3};
      end
      OPC_MISCMEM,
      OPC_SYSTEM: dec_kind = KIND_NOP;  // Fences and CSR ops do nothing here
      default:    ;
    endcase
  end

  ////////////////////
  // Handshakes
  ////////////////////
  assign need_bubble   = instr_valid_i && bubble;
  assign instr_ready_o = uop_o.ready && !need_bubble;  // Hold fetch during the bubble
  assign accept        = instr_valid_i && instr_ready_o;
  assign offer         = need_bubble && uop_o.ready;

  // Bubble wins over the decoded fields and zeroes them all
  assign uop_o.valid    = instr_valid_i;
  assign uop_o.kind     = need_bubble ? KIND_BUBBLE : dec_kind;
  assign uop_o.alu_sel  = need_bubble ? '0 : dec_alu_sel;
  assign uop_o.rs1      = need_bubble ? '0 : dec_rs1;
  assign uop_o.rs2      = need_bubble ? '0 : dec_rs2;
  assign uop_o.rd       = need_bubble ? '0 : dec_rd;
  assign uop_o.imm      = need_bubble ? '0 : imm;
  assign uop_o.use_pc   = need_bubble ? 1'b0 : dec_use_pc;
  assign uop_o.use_imm  = need_bubble ? 1'b0 : dec_use_imm;
  assign uop_o.wb       = need_bubble ? 1'b0 : dec_wb;
  assign uop_o.lsu_ctrl = need_bubble ? '0 : dec_lsu_ctrl;

  // One bubble per hazard, the tracker flag must block a second one
  a_single_bubble: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (offer) |=> !(uop_o.valid && uop_o.kind == KIND_BUBBLE));

endmodule

/* hw/uop_issue.sv */
////////////////////
// Single-entry output register, released to execute under credit control
////////////////////
`timescale 1ns/1ps

module uop_issue #(
  parameter int CREDITS = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rstn_i,
  uop_if.sink                                     uop_i,
  input  logic                                    credit_i,  // One slot freed downstream
  output logic                                    uop_valid_o,
  output logic [rv_decode_pkg::KIND_W-1:0]        uop_kind_o,
  output logic [rv_decode_pkg::ALU_SEL_W-1:0]     alu_sel_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0]    rs1_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0]    rs2_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0]    rd_o,
  output logic [rv_decode_pkg::XLEN-1:0]          imm_o,
  output logic                                    use_pc_o,
  output logic                                    use_imm_o,
  output logic                                    wb_o,
  output logic [rv_decode_pkg::LSU_CTRL_W-1:0]    lsu_ctrl_o
);
  localparam int CNT_W = $clog2(CREDITS + 1);

  logic             full_q;
  logic [CNT_W-1:0] cnt_q;
  logic             send;
  logic             load;

  assign send        = full_q && (cnt_q != '0);
  assign uop_valid_o = send;
  assign uop_i.ready = !full_q || send;  // Refill in the same cycle as a send
  assign load        = uop_i.valid && uop_i.ready;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      full_q <= 1'b0;
      cnt_q  <= CNT_W'(CREDITS);
    end else begin
      if (load) begin
        full_q <= 1'b1;
      end else if (send) begin
        full_q <= 1'b0;
      end
      case ({send, credit_i})
        2'b10:   cnt_q <= cnt_q - 1'b1;
        2'b01:   cnt_q <= cnt_q + 1'b1;
        default: ;  // Send and return cancel out
      endcase
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      uop_kind_o <= uop_i.kind;
      alu_sel_o  <= uop_i.alu_sel;
      rs1_o      <= uop_i.rs1;
      rs2_o      <= uop_i.rs2;
      rd_o       <= uop_i.rd;
      imm_o      <= uop_i.imm;
      use_pc_o   <= uop_i.use_pc;
      use_imm_o  <= uop_i.use_imm;
      wb_o       <= uop_i.wb;
      lsu_ctrl_o <= uop_i.lsu_ctrl;
    end
  end

  // Consumer must not return more credits than it was given
  a_cnt_max: assert property (@(posedge clk_i) disable iff (!rstn_i)
    cnt_q <= CNT_W'(CREDITS));

  // A waiting micro-op stays offered and unchanged until it is taken
  a_hold_while_waiting: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (uop_i.valid && !uop_i.ready) |=> (uop_i.valid && $stable({uop_i.kind,
      uop_i.alu_sel, uop_i.rs1, uop_i.rs2, uop_i.rd, uop_i.imm, uop_i.use_pc,
      uop_i.use_imm, uop_i.wb, uop_i.lsu_ctrl})));

endmodule

/* hw/rv_decoder_top.sv */
////////////////////
// RV32I decode stage: fetch valid/ready in, credit-controlled micro-ops out
////////////////////
`timescale 1ns/1ps

module rv_decoder_top #(
  parameter int CREDITS = 4  // Micro-op slots in the execute stage
) (
  input  logic                                 clk_i,
  input  logic                                 rstn_i,

  // Fetch side
  input  logic [rv_decode_pkg::XLEN-1:0]       instr_i,
  input  logic                                 instr_valid_i,
  output logic                                 instr_ready_o,

  // Execute side
  input  logic                                 credit_i,
  output logic                                 uop_valid_o,
  output logic [rv_decode_pkg::KIND_W-1:0]     uop_kind_o,
  output logic [rv_decode_pkg::ALU_SEL_W-1:0]  alu_sel_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [rv_decode_pkg::XLEN-1:0]       imm_o,
  output logic                                 use_pc_o,
  output logic                                 use_imm_o,
  output logic                                 wb_o,
  output logic [rv_decode_pkg::LSU_CTRL_W-1:0] lsu_ctrl_o
);

  uop_if uop_bus ();

  ////////////////////
  // Decode
  ////////////////////
  decode_ctrl decode_ctrl_i (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),  // Raw word, viewed as the format union inside
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .uop_o         (uop_bus.source)
  );

  ////////////////////
  // Issue
  ////////////////////
  uop_issue #(
    .CREDITS (CREDITS)
  ) uop_issue_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .uop_i       (uop_bus.sink),
    .credit_i    (credit_i),
    .uop_valid_o (uop_valid_o),
    .uop_kind_o  (uop_kind_o),
    .alu_sel_o   (alu_sel_o),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .rd_o        (rd_o),
    .imm_o       (imm_o),
    .use_pc_o    (use_pc_o),
    .use_imm_o   (use_imm_o),
    .wb_o        (wb_o),
    .lsu_ctrl_o  (lsu_ctrl_o)
  );

endmodule

/* test/tb_rv_decoder.sv */
////////////////////
// Testbench for the RV32I decode stage, replays the golden instruction list
// Returns credits after random delays and checks every micro-op in order
////////////////////
`timescale 1ns/1ps

module tb_rv_decoder;

  localparam int CREDITS    = 4;
  localparam int MAX_LINES  = 64;
  localparam int NUM_FIELDS = 10;
  localparam int WAIT_LIMIT = 200;  // Cycles per wait loop

  logic        clk_i;
  logic        rstn_i;
  logic [31:0] instr_i;
  logic        instr_valid_i;
  logic        instr_ready_o;
  logic        credit_i = 1'b0;
  logic        uop_valid_o;
  logic [2:0]  uop_kind_o;
  logic [3:0]  alu_sel_o;
  logic [4:0]  rs1_o, rs2_o, rd_o;
  logic [31:0] imm_o;
  logic        use_pc_o, use_imm_o, wb_o;
  logic [3:0]  lsu_ctrl_o;

  logic [31:0] instr_q [$];                   // Real instructions only
  logic [31:0] exp_f [MAX_LINES][NUM_FIELDS];  // Expected micro-ops, bubbles too
  int          n_exp = 0;
  int          exp_idx = 0;
  int          outstanding = 0;
  int          cycle = 0;
  int          credit_due [$];  // Cycle at which each credit goes back
  string       field_names [NUM_FIELDS] = '{"kind", "alu_sel", "rs1", "rs2", "rd", "imm",
                                            "use_pc", "use_imm", "wb", "lsu_ctrl"};

  rv_decoder_top #(.CREDITS(CREDITS)) rv_decoder_top_i (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
      abort_run();
    end
  endtask

  task automatic load_golden();
    int          fd;
    int          n;
    string       line;
    string       tok;
    logic [31:0] v [NUM_FIELDS];
    fd = $fopen("test/rv_decoder_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file test/rv_decoder_golden.txt");
      abort_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin  // Skip column notes
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", tok, v[0], v[1], v[2],
                      v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
          if (n != 11 || n_exp >= MAX_LINES) begin
            $display("Golden file line is malformed or beyond capacity: %s", line);
            abort_run();
          end else begin
            if (tok != "-") instr_q.push_back(tok.atohex());
            for (int k = 0; k < NUM_FIELDS; k++) exp_f[n_exp][k] = v[k];
            n_exp = n_exp + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send_instr(input logic [31:0] word);
    int   waited;
    logic taken;
    waited        = 0;
    taken         = 1'b0;
    instr_i       = word;
    instr_valid_i = 1'b1;
    while (!taken) begin
      #1 taken = instr_ready_o;  // Settled well before the rising edge
      @(negedge clk_i);
      waited = waited + 1;
      if (!taken && waited > WAIT_LIMIT) begin
        $display("Timeout: the decoder never accepted instruction %h", word);
        abort_run();
      end
    end
    instr_valid_i = 1'b0;
    instr_i       = '0;
  endtask

  task automatic check_uop();
    logic [31:0] got [NUM_FIELDS];
    if (exp_idx >= n_exp) begin
      $display("A micro-op arrived at %0t ns after the whole golden list was seen", $time);
      abort_run();
    end else begin
      got = '{32'(uop_kind_o), 32'(alu_sel_o), 32'(rs1_o), 32'(rs2_o), 32'(rd_o), imm_o,
              32'(use_pc_o), 32'(use_imm_o), 32'(wb_o), 32'(lsu_ctrl_o)};
      for (int k = 0; k < NUM_FIELDS; k++) begin
        check_value($sformatf("uop %0d %s", exp_idx, field_names[k]), got[k], exp_f[exp_idx][k]);
      end
      outstanding = outstanding + 1;
      check_value("outstanding micro-ops within credits", 32'(outstanding <= CREDITS), 32'd1);
      credit_due.push_back(cycle + int'($urandom_range(16, 4)));  // Slow consumer
      exp_idx = exp_idx + 1;
    end
  endtask

  ////////////////////
  // Execute-side model with at most one credit pulse per cycle
  ////////////////////
  always @(negedge clk_i) begin
    if (rstn_i) begin
      cycle = cycle + 1;
      if (uop_valid_o) check_uop();
      credit_i = 1'b0;
      if (credit_due.size() != 0 && credit_due[0] <= cycle) begin
        void'(credit_due.pop_front());
        credit_i    = 1'b1;
        outstanding = outstanding - 1;
      end
    end
  end

  initial begin
    int waited;
    void'($urandom(32'h3da9e0c4));
    clk_i         = 1'b0;
    rstn_i        = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    load_golden();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;
    foreach (instr_q[i]) begin
      repeat ($urandom_range(3, 0)) @(negedge clk_i);  // Fetch gaps
      send_instr(instr_q[i]);
    end
    waited = 0;
    while (exp_idx < n_exp || credit_due.size() != 0) begin
      @(negedge clk_i);
      waited = waited + 1;
      if (waited > WAIT_LIMIT) begin
        $display("Timeout: %0d of %0d micro-ops arrived, %0d credits not returned",
                 exp_idx, n_exp, credit_due.size());
        abort_run();
      end
    end
    repeat (10) @(negedge clk_i);  // Quiet window where a late duplicate would show up
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* test/rv_decoder_golden.txt */
# instr kind alu_sel rs1 rs2 rd imm use_pc use_imm wb lsu_ctrl, all hex
# instr is - for a bubble micro-op inserted before the next instruction
00500093 1 0 00 00 01 00000005 0 1 1 0
FFF00113 1 0 00 00 02 FFFFFFFF 0 1 1 0
- 4 0 00 00 00 00000000 0 0 0 0
002081B3 1 0 01 02 03 00000000 0 0 1 0
40628233 1 8 05 06 04 00000000 0 0 1 0
- 4 0 00 00 00 00000000 0 0 0 0
00321293 1 1 04 00 05 00000003 0 1 1 0
01F3D313 1 5 07 00 06 0000001F 0 1 1 0
- 4 0 00 00 00 00000000 0 0 0 0
40435393 1 D 06 00 07 00000004 0 1 1 0
7F00F413 1 7 01 00 08 000007F0 0 1 1 0
123454B7 1 0 00 00 09 12345000 0 1 1 0
FFFFF517 1 0 00 00 0A FFFFF000 1 1 1 0
- 4 0 00 00 00 00000000 0 0 0 0
FFC52583 2 0 0A 00 0B FFFFFFFC 0 1 1 2
- 4 0 00 00 00 00000000 0 0 0 0
00B12423 3 0 02 0B 00 00000008 0 1 0 A
FE358FA3 3 0 0B 03 00 FFFFFFFF 0 1 0 8
0020D603 2 0 01 00 0C 00000002 0 1 1 5
0FF0000F 5 0 00 00 00 00000000 0 0 0 0
00C606B3 1 0 0C 0C 0D 00000000 0 0 1 0
00000073 5 0 00 00 00 00000000 0 0 0 0
FFFFFFFF 6 0 00 00 00 00000000 0 0 0 0
00108013 1 0 01 00 00 00000001 0 1 1 0
000007B3 1 0 00 00 0F 00000000 0 0 1 0
- 4 0 00 00 00 00000000 0 0 0 0
00F7C833 1 4 0F 0F 10 00000000 0 0 1 0
- 4 0 00 00 00 00000000 0 0 0 0
401858B3 1 D 10 01 11 00000000 0 0 1 0
ABCDE06B 6 0 00 00 00 00000000 0 0 0 0

/* verilog.f */
hw/rv_decode_pkg.sv
hw/uop_if.sv
hw/imm_gen.sv
hw/hazard_tracker.sv
hw/decode_ctrl.sv
hw/uop_issue.sv
hw/rv_decoder_top.sv
test/tb_rv_decoder.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_decoder \
  -f verilog.f -o tb_rv_decoder
./obj_dir/tb_rv_decoder 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  exit 1
fi
